/* design/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define EX_LANES        3              // issue lanes and bus lanes
`define EX_XLEN         32
`define EX_TAG_BITS     5              // rob tag width
`define EX_MULT_STAGES  4
`define EX_SLOTS        (2 * `EX_LANES) // mult slots first, then alu slots

// alu opcodes
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_SLT   4'd5
`define ALU_SLTU  4'd6
`define ALU_SLL   4'd7
`define ALU_SRL   4'd8
`define ALU_SRA   4'd9

// multiplier opcodes
`define MUL_LO    4'd0
`define MUL_HI    4'd1
`define MUL_HSU   4'd2
`define MUL_HU    4'd3

`endif

/* design/ex_pkg.sv */
`include "ex_consts.svh"

package ex_pkg;

    // operand and result word
    typedef logic [`EX_XLEN-1:0] data_t;

    // reorder buffer tag
    typedef logic [`EX_TAG_BITS-1:0] tag_t;

    // opcode, meaning depends on the target unit
    typedef logic [3:0] op_t;

    // target unit: 0 alu, 1 multiplier
    typedef logic fu_kind_t;

endpackage

/* design/alu_unit.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module alu_unit (
    input  logic          clock,
    input  logic          reset,
    input  logic          clear_i,
    input  logic          start_i,
    input  ex_pkg::op_t   op_i,
    input  ex_pkg::data_t a_i,
    input  ex_pkg::data_t b_i,
    input  ex_pkg::tag_t  tag_i,
    input  logic          take_i,
    output logic          ready_o,
    output logic          done_valid_o,
    output ex_pkg::tag_t  done_tag_o,
    output ex_pkg::data_t done_value_o
);

    import ex_pkg::*;

    localparam int SHAMT_BITS = $clog2(`EX_XLEN);

    data_t                 result;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  accept;

    assign shamt = b_i[SHAMT_BITS-1:0];  // low bits of b only

    // free output register, or the buffer empties it this cycle
    assign ready_o = ~done_valid_o | take_i;
    assign accept  = start_i & ready_o;   // issues to a busy unit are dropped

    always_comb begin
        case (op_i)
            `ALU_ADD:  result = a_i + b_i;
            `ALU_SUB:  result = a_i - b_i;
            `ALU_AND:  result = a_i & b_i;
            `ALU_OR:   result = a_i | b_i;
            `ALU_XOR:  result = a_i ^ b_i;
            `ALU_SLT:  result = data_t'($signed(a_i) < $signed(b_i));
            `ALU_SLTU: result = data_t'(a_i < b_i);
            `ALU_SLL:  result = a_i << shamt;
            `ALU_SRL:  result = a_i >> shamt;
            `ALU_SRA:  result = $signed(a_i) >>> shamt;  // sign fill
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            done_valid_o <= 1'b0;
        end else if (accept) begin
            done_valid_o <= 1'b1;   // new result replaces a taken one
        end else if (take_i) begin
            done_valid_o <= 1'b0;
        end
    end

    // result payload, held until the next accepted start
    always_ff @(posedge clock) begin
        if (accept) begin
            done_tag_o   <= tag_i;
            done_value_o <= result;
        end
    end

endmodule

/* design/mult_unit.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module mult_unit (
    input  logic          clock,
    input  logic          reset,
    input  logic          clear_i,
    input  logic          start_i,
    input  ex_pkg::op_t   op_i,
    input  ex_pkg::data_t a_i,
    input  ex_pkg::data_t b_i,
    input  ex_pkg::tag_t  tag_i,
    input  logic          take_i,
    output logic          ready_o,
    output logic          done_valid_o,
    output ex_pkg::tag_t  done_tag_o,
    output ex_pkg::data_t done_value_o
);

    import ex_pkg::*;

    localparam int STAGES    = `EX_MULT_STAGES;
    localparam int PROD_BITS = 2 * `EX_XLEN;
    localparam int CHUNK     = `EX_XLEN / STAGES;  // b bits folded in per stage

    logic [STAGES-1:0]    vld;
    tag_t                 tag_q  [STAGES];
    op_t                  op_q   [STAGES];
    logic [PROD_BITS-1:0] prod_q [STAGES];
    logic [PROD_BITS-1:0] a_q    [STAGES-1];  // extended operands, not needed in last stage
    logic [PROD_BITS-1:0] b_q    [STAGES-1];

    logic                 a_signed;
    logic                 b_signed;
    logic [PROD_BITS-1:0] a_ext;
    logic [PROD_BITS-1:0] b_ext;
    logic                 freeze;
    logic                 accept;

    // a times one slice of b, placed at the slice position
    // the last slice takes all upper bits so the sign extension is covered
    function automatic logic [PROD_BITS-1:0] partial(input logic [PROD_BITS-1:0] a,
                                                     input logic [PROD_BITS-1:0] b,
                                                     input int s);
        logic [PROD_BITS-1:0] chunk;
        chunk = b >> (s * CHUNK);
        if (s < STAGES - 1) begin
            chunk = chunk & ((PROD_BITS'(1) << CHUNK) - PROD_BITS'(1));
        end
        return (a * chunk) << (s * CHUNK);
    endfunction

    always_comb begin
        a_signed = (op_i == `MUL_LO) || (op_i == `MUL_HI) || (op_i == `MUL_HSU);
        b_signed = (op_i == `MUL_LO) || (op_i == `MUL_HI);
        a_ext    = {{`EX_XLEN{a_signed & a_i[`EX_XLEN-1]}}, a_i};
        b_ext    = {{`EX_XLEN{b_signed & b_i[`EX_XLEN-1]}}, b_i};
    end

    // whole pipe stops while the last result waits for its slot
    assign freeze  = vld[STAGES-1] & ~take_i;
    assign ready_o = ~freeze;
    assign accept  = start_i & ready_o;

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            vld <= '0;
        end else if (!freeze) begin
            vld <= {vld[STAGES-2:0], accept};
        end
    end

    always_ff @(posedge clock) begin
        if (!freeze) begin
            tag_q[0]  <= tag_i;
            op_q[0]   <= op_i;
            a_q[0]    <= a_ext;
            b_q[0]    <= b_ext;
            prod_q[0] <= partial(a_ext, b_ext, 0);
            for (int s = 1; s < STAGES; s++) begin
                tag_q[s]  <= tag_q[s-1];
                op_q[s]   <= op_q[s-1];
                prod_q[s] <= prod_q[s-1] + partial(a_q[s-1], b_q[s-1], s);
            end
            for (int s = 1; s < STAGES - 1; s++) begin
                a_q[s] <= a_q[s-1];
                b_q[s] <= b_q[s-1];
            end
        end
    end

    assign done_valid_o = vld[STAGES-1];
    assign done_tag_o   = tag_q[STAGES-1];
    // low word only for MUL_LO, the high variants differ only in extension
    assign done_value_o = (op_q[STAGES-1] == `MUL_LO) ? prod_q[STAGES-1][`EX_XLEN-1:0]
                                                      : prod_q[STAGES-1][PROD_BITS-1:`EX_XLEN];

endmodule

/* design/complete_buffer.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module complete_buffer (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          clear_i,
    // one slot per unit
    input  logic          [`EX_SLOTS-1:0] done_valid_i,
    input  ex_pkg::tag_t  [`EX_SLOTS-1:0] done_tag_i,
    input  ex_pkg::data_t [`EX_SLOTS-1:0] done_value_i,
    output logic          [`EX_SLOTS-1:0] take_o,
    // registered bus
    output logic          [`EX_LANES-1:0] cdb_valid_o,
    output ex_pkg::tag_t  [`EX_LANES-1:0] cdb_tag_o,
    output ex_pkg::data_t [`EX_LANES-1:0] cdb_value_o
);

    import ex_pkg::*;

    logic  [`EX_SLOTS-1:0] slot_vld;
    tag_t                  slot_tag [`EX_SLOTS];
    data_t                 slot_val [`EX_SLOTS];

    logic  [`EX_SLOTS-1:0] occupied;   // held entries plus this cycle's fills
    tag_t                  ent_tag [`EX_SLOTS];
    data_t                 ent_val [`EX_SLOTS];
    logic  [`EX_SLOTS-1:0] drain;

    logic  [`EX_LANES-1:0] bus_vld_n;
    tag_t  [`EX_LANES-1:0] bus_tag_n;
    data_t [`EX_LANES-1:0] bus_val_n;

    // a unit hands over only into an empty slot
    assign take_o   = done_valid_i & ~slot_vld;
    assign occupied = slot_vld | take_o;

    // held entry wins, otherwise the incoming one
    always_comb begin
        for (int s = 0; s < `EX_SLOTS; s++) begin
            ent_tag[s] = slot_vld[s] ? slot_tag[s] : done_tag_i[s];
            ent_val[s] = slot_vld[s] ? slot_val[s] : done_value_i[s];
        end
    end

    // lowest occupied slots go out first, lane 0 gets the lowest
    always_comb begin
        int picked;
        picked    = 0;
        drain     = '0;
        bus_vld_n = '0;
        bus_tag_n = '0;
        bus_val_n = '0;
        for (int s = 0; s < `EX_SLOTS; s++) begin
            if (occupied[s] && picked < `EX_LANES) begin
                drain[s]          = 1'b1;
                bus_vld_n[picked] = 1'b1;
                bus_tag_n[picked] = ent_tag[s];
                bus_val_n[picked] = ent_val[s];
                picked            = picked + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            slot_vld    <= '0;
            cdb_valid_o <= '0;
        end else begin
            slot_vld    <= occupied & ~drain;  // leftovers wait for a free lane
            cdb_valid_o <= bus_vld_n;
        end
    end

    always_ff @(posedge clock) begin
        for (int s = 0; s < `EX_SLOTS; s++) begin
            if (take_o[s]) begin
                slot_tag[s] <= done_tag_i[s];
                slot_val[s] <= done_value_i[s];
            end
        end
        cdb_tag_o   <= bus_tag_n;
        cdb_value_o <= bus_val_n;
    end

endmodule

/* design/ex_stage.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  clear_i,
    // issue lanes
    input  logic            [`EX_LANES-1:0]       issue_valid_i,
    input  ex_pkg::fu_kind_t [`EX_LANES-1:0]      issue_kind_i,
    input  ex_pkg::op_t     [`EX_LANES-1:0]       issue_op_i,
    input  ex_pkg::data_t   [`EX_LANES-1:0]       issue_a_i,
    input  ex_pkg::data_t   [`EX_LANES-1:0]       issue_b_i,
    input  ex_pkg::tag_t    [`EX_LANES-1:0]       issue_tag_i,
    // unit availability
    output logic            [`EX_LANES-1:0]       alu_ready_o,
    output logic            [`EX_LANES-1:0]       mult_ready_o,
    // common data bus
    output logic            [`EX_LANES-1:0]       cdb_valid_o,
    output ex_pkg::tag_t    [`EX_LANES-1:0]       cdb_tag_o,
    output ex_pkg::data_t   [`EX_LANES-1:0]       cdb_value_o
);

    import ex_pkg::*;

    logic  [`EX_LANES-1:0] alu_start;
    logic  [`EX_LANES-1:0] mult_start;

    // unit to buffer, slots 0..2 mult, 3..5 alu
    logic  [`EX_SLOTS-1:0] done_valid;
    tag_t  [`EX_SLOTS-1:0] done_tag;
    data_t [`EX_SLOTS-1:0] done_value;
    logic  [`EX_SLOTS-1:0] take;

    for (genvar i = 0; i < `EX_LANES; i++) begin : g_lane
        // kind bit picks the unit on this lane
        assign alu_start[i]  = issue_valid_i[i] & ~issue_kind_i[i];
        assign mult_start[i] = issue_valid_i[i] &  issue_kind_i[i];

        mult_unit mult_inst (
            .clock        (clock),
            .reset        (reset),
            .clear_i      (clear_i),
            .start_i      (mult_start[i]),
            .op_i         (issue_op_i[i]),
            .a_i          (issue_a_i[i]),
            .b_i          (issue_b_i[i]),
            .tag_i        (issue_tag_i[i]),
            .take_i       (take[i]),
            .ready_o      (mult_ready_o[i]),
            .done_valid_o (done_valid[i]),
            .done_tag_o   (done_tag[i]),
            .done_value_o (done_value[i])
        );

        alu_unit alu_inst (
            .clock        (clock),
            .reset        (reset),
            .clear_i      (clear_i),
            .start_i      (alu_start[i]),
            .op_i         (issue_op_i[i]),
            .a_i          (issue_a_i[i]),
            .b_i          (issue_b_i[i]),
            .tag_i        (issue_tag_i[i]),
            .take_i       (take[`EX_LANES + i]),
            .ready_o      (alu_ready_o[i]),
            .done_valid_o (done_valid[`EX_LANES + i]),
            .done_tag_o   (done_tag[`EX_LANES + i]),
            .done_value_o (done_value[`EX_LANES + i])
        );
    end

    complete_buffer complete_buffer_inst (
        .clock        (clock),
        .reset        (reset),
        .clear_i      (clear_i),
        .done_valid_i (done_valid),
        .done_tag_i   (done_tag),
        .done_value_i (done_value),
        .take_o       (take),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o)
    );

endmodule

/* sim/ex_stage_tb.sv */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_tb;

    import ex_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int N_ROWS      = 25;
    localparam int N_RANDOM    = 300;
    localparam int N_TAGS      = 1 << `EX_TAG_BITS;
    localparam int WATCHDOG_NS = CLK_PERIOD * (20 * (N_ROWS + N_RANDOM) + 1000);
    localparam logic [31:0] SEED = 32'h5259_615b;

    logic                           clock;
    logic                           reset;
    logic                           clear_i;
    logic     [`EX_LANES-1:0]       issue_valid_i;
    fu_kind_t [`EX_LANES-1:0]       issue_kind_i;
    op_t      [`EX_LANES-1:0]       issue_op_i;
    data_t    [`EX_LANES-1:0]       issue_a_i;
    data_t    [`EX_LANES-1:0]       issue_b_i;
    tag_t     [`EX_LANES-1:0]       issue_tag_i;
    logic     [`EX_LANES-1:0]       alu_ready_o;
    logic     [`EX_LANES-1:0]       mult_ready_o;
    logic     [`EX_LANES-1:0]       cdb_valid_o;
    tag_t     [`EX_LANES-1:0]       cdb_tag_o;
    data_t    [`EX_LANES-1:0]       cdb_value_o;

    // stimulus table
    fu_kind_t row_kind [N_ROWS];
    op_t      row_op   [N_ROWS];
    data_t    row_a    [N_ROWS];
    data_t    row_b    [N_ROWS];
    tag_t     row_tag  [N_ROWS];
    data_t    row_exp  [N_ROWS];
    int       row_count;

    // scoreboard indexed by tag
    logic [N_TAGS-1:0] pending;
    data_t             exp_value [N_TAGS];
    int                pending_count;
    int                tag_ptr;
    logic [31:0]       rng_state;

    ex_stage ex_stage_inst (
        .clock         (clock),
        .reset         (reset),
        .clear_i       (clear_i),
        .issue_valid_i (issue_valid_i),
        .issue_kind_i  (issue_kind_i),
        .issue_op_i    (issue_op_i),
        .issue_a_i     (issue_a_i),
        .issue_b_i     (issue_b_i),
        .issue_tag_i   (issue_tag_i),
        .alu_ready_o   (alu_ready_o),
        .mult_ready_o  (mult_ready_o),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_tag_o     (cdb_tag_o),
        .cdb_value_o   (cdb_value_o)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_bit(logic got, logic exp, string name);
        if (got !== exp)
            stop_with_error($sformatf("mismatch at %0t: %s is %b, expected %b",
                                      $time, name, got, exp));
    endtask

    task automatic check_data(data_t got, data_t exp, string name);
        if (got !== exp)
            stop_with_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    // tag must be one of those still in flight
    task automatic check_tag(tag_t got, string name);
        if (pending[got] !== 1'b1)
            stop_with_error($sformatf("mismatch at %0t: %s is %0d, expected a tag of %b",
                                      $time, name, got, pending));
    endtask

    task automatic check_cycles(int got, int exp, string name);
        if (got != exp)
            stop_with_error($sformatf("mismatch at %0t: %s is %0d cycles, expected %0d",
                                      $time, name, got, exp));
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected result straight from the opcode rules
    function automatic data_t ref_result(fu_kind_t kind, op_t op, data_t a, data_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] prod;
        logic [4:0]         sh;
        data_t              r;
        sh = b[4:0];
        r  = '0;
        if (kind == 1'b0) begin
            case (op)
                `ALU_ADD:  r = a + b;
                `ALU_SUB:  r = a - b;
                `ALU_AND:  r = a & b;
                `ALU_OR:   r = a | b;
                `ALU_XOR:  r = a ^ b;
                `ALU_SLT:  r = (a[31] != b[31]) ? data_t'(a[31]) : data_t'(a < b);
                `ALU_SLTU: r = data_t'(a < b);
                `ALU_SLL:  r = a << sh;
                `ALU_SRL:  r = a >> sh;
                `ALU_SRA:  r = a[31] ? ~((~a) >> sh) : (a >> sh);  // ones shifted in
                default:   r = '0;
            endcase
        end else begin
            sa   = (op == `MUL_HU) ? {32'd0, a} : {{32{a[31]}}, a};
            sb   = (op == `MUL_LO || op == `MUL_HI) ? {{32{b[31]}}, b} : {32'd0, b};
            prod = sa * sb;
            r    = (op == `MUL_LO) ? prod[31:0] : prod[63:32];
        end
        return r;
    endfunction

    function automatic logic unit_ready(int l, fu_kind_t kind);
        return kind ? mult_ready_o[l] : alu_ready_o[l];
    endfunction

    function automatic bit find_free_tag(output tag_t t);
        int idx;
        for (int n = 0; n < N_TAGS; n++) begin
            idx = (tag_ptr + n) % N_TAGS;
            if (!pending[idx]) begin
                t       = tag_t'(idx);
                tag_ptr = (idx + 1) % N_TAGS;
                return 1'b1;
            end
        end
        t = '0;
        return 1'b0;
    endfunction

    task automatic add_row(fu_kind_t kind, op_t op, data_t a, data_t b, data_t expv);
        row_kind[row_count] = kind;
        row_op[row_count]   = op;
        row_a[row_count]    = a;
        row_b[row_count]    = b;
        row_tag[row_count]  = tag_t'(row_count);
        row_exp[row_count]  = expv;
        row_count++;
    endtask

    task automatic build_table();
        row_count = 0;
        add_row(1'b0, `ALU_ADD,  32'h0000_0005, 32'hFFFF_FFFD, 32'h0000_0002);
        add_row(1'b0, `ALU_SUB,  32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE);
        add_row(1'b0, `ALU_AND,  32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200);
        add_row(1'b0, `ALU_OR,   32'hF000_0000, 32'h0000_000F, 32'hF000_000F);
        add_row(1'b0, `ALU_XOR,  32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555);
        add_row(1'b0, `ALU_SLT,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001);
        add_row(1'b0, `ALU_SLT,  32'h0000_0005, 32'h8000_0000, 32'h0000_0000);
        add_row(1'b0, `ALU_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
        add_row(1'b0, `ALU_SLTU, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0001);
        add_row(1'b0, `ALU_SLL,  32'h0000_0003, 32'h0000_0024, 32'h0000_0030);
        add_row(1'b0, `ALU_SRL,  32'h8000_0010, 32'h0000_0004, 32'h0800_0001);
        add_row(1'b0, `ALU_SRA,  32'h8000_0010, 32'h0000_0004, 32'hF800_0001);
        add_row(1'b0, `ALU_SRA,  32'hFFFF_FF00, 32'h0000_003F, 32'hFFFF_FFFF);
        add_row(1'b1, `MUL_LO,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
        add_row(1'b1, `MUL_LO,   32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
        add_row(1'b1, `MUL_LO,   32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
        add_row(1'b1, `MUL_HI,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
        add_row(1'b1, `MUL_HI,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_row(1'b1, `MUL_HI,   32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFF);
        add_row(1'b1, `MUL_HSU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        add_row(1'b1, `MUL_HSU,  32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
        add_row(1'b1, `MUL_HSU,  32'h0000_0001, 32'h8000_0000, 32'h0000_0000);
        add_row(1'b1, `MUL_HU,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
        add_row(1'b1, `MUL_HU,   32'h8000_0000, 32'h0000_0002, 32'h0000_0001);
        add_row(1'b1, `MUL_HU,   32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0000);
    endtask

    // drives one lane for one cycle and records the expected result
    task automatic drive_lane(int l, fu_kind_t kind, op_t op, data_t a, data_t b, tag_t t,
                              data_t expv);
        issue_valid_i[l] = 1'b1;
        issue_kind_i[l]  = kind;
        issue_op_i[l]    = op;
        issue_a_i[l]     = a;
        issue_b_i[l]     = b;
        issue_tag_i[l]   = t;
        pending[t]       = 1'b1;
        exp_value[t]     = expv;
        pending_count++;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (pending_count != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > 200)
                stop_with_error($sformatf("%0d results never reached the bus", pending_count));
        end
    endtask

    task automatic check_idle(string when);
        for (int l = 0; l < `EX_LANES; l++) begin
            check_bit(cdb_valid_o[l], 1'b0, $sformatf("%s cdb_valid_o[%0d]", when, l));
            check_bit(alu_ready_o[l], 1'b1, $sformatf("%s alu_ready_o[%0d]", when, l));
            check_bit(mult_ready_o[l], 1'b1, $sformatf("%s mult_ready_o[%0d]", when, l));
        end
    endtask

    task automatic run_table();
        int l;
        int waited;
        for (int r = 0; r < N_ROWS; r++) begin
            l = r % `EX_LANES;
            @(negedge clock);
            issue_valid_i = '0;
            waited = 0;
            while (!unit_ready(l, row_kind[r])) begin
                @(negedge clock);
                waited++;
                if (waited > 100)
                    stop_with_error($sformatf("lane %0d never ready for table row %0d", l, r));
            end
            drive_lane(l, row_kind[r], row_op[r], row_a[r], row_b[r], row_tag[r], row_exp[r]);
        end
        @(negedge clock);
        issue_valid_i = '0;
        wait_drained();
    endtask

    // rising edges from the start of the issue cycle until the entry is on lane 0
    task automatic measure_latency(fu_kind_t kind, op_t op, data_t a, data_t b, tag_t t,
                                   int exp_cycles, string name);
        int cycles;
        @(negedge clock);
        issue_valid_i = '0;
        drive_lane(0, kind, op, a, b, t, ref_result(kind, op, a, b));
        @(negedge clock);
        issue_valid_i = '0;
        cycles = 1;   // accepting edge already passed
        while (cdb_valid_o[0] !== 1'b1) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > 20)
                stop_with_error($sformatf("%s result never appeared on the bus", name));
        end
        check_cycles(cycles, exp_cycles, name);
        wait_drained();
    endtask

    task automatic run_random();
        int          issued;
        logic [31:0] r;
        fu_kind_t    kind;
        op_t         op;
        data_t       a;
        data_t       b;
        tag_t        t;
        issued = 0;
        while (issued < N_RANDOM) begin
            @(negedge clock);
            issue_valid_i = '0;
            for (int l = 0; l < `EX_LANES; l++) begin
                r    = next_rand();
                kind = fu_kind_t'(r[0]);
                if (issued < N_RANDOM && unit_ready(l, kind)) begin
                    if (find_free_tag(t)) begin
                        op = kind ? op_t'(r[5:4]) : op_t'(r[11:8] % 10);
                        a  = next_rand();
                        b  = next_rand();
                        if (r[14:12] == 3'd0) a = 32'h8000_0000;  // corner operands now and then
                        if (r[17:15] == 3'd0) b = 32'hFFFF_FFFF;
                        drive_lane(l, kind, op, a, b, t, ref_result(kind, op, a, b));
                        issued++;
                    end
                end
            end
        end
        @(negedge clock);
        issue_valid_i = '0;
        wait_drained();
    endtask

    task automatic run_clear();
        @(negedge clock);
        for (int l = 0; l < `EX_LANES; l++)
            drive_lane(l, 1'b1, `MUL_HU, 32'h1234_5678 + l, 32'h9ABC_DEF0, tag_t'(26 + l), '0);
        @(negedge clock);
        for (int l = 0; l < `EX_LANES; l++)
            drive_lane(l, 1'b0, `ALU_ADD, data_t'(l), data_t'(l), tag_t'(29 + l), '0);
        @(negedge clock);
        issue_valid_i = '0;
        clear_i       = 1'b1;
        pending       = '0;   // squashed work must never show up
        pending_count = 0;
        @(negedge clock);
        clear_i = 1'b0;
        check_idle("after clear");
        repeat (12) @(negedge clock);
        drive_lane(0, 1'b0, `ALU_XOR, 32'h0F0F_0F0F, 32'hFFFF_0000, tag_t'(3), 32'hF0F0_0F0F);
        @(negedge clock);
        issue_valid_i = '0;
        wait_drained();
    endtask

    // bus monitor samples just after the registers update
    initial begin
        forever begin
            @(posedge clock);
            #1;
            for (int l = 0; l < `EX_LANES; l++) begin
                if (cdb_valid_o[l] === 1'b1) begin
                    if (l > 0)
                        check_bit(cdb_valid_o[l-1], 1'b1, $sformatf("cdb_valid_o[%0d]", l - 1));
                    check_tag(cdb_tag_o[l], $sformatf("cdb_tag_o[%0d]", l));
                    check_data(cdb_value_o[l], exp_value[cdb_tag_o[l]],
                               $sformatf("cdb_value_o[%0d]", l));
                    pending[cdb_tag_o[l]] = 1'b0;
                    pending_count--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("timeout, the tests did not finish in the expected time");
    end

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        clear_i       = 1'b0;
        issue_valid_i = '0;
        issue_kind_i  = '0;
        issue_op_i    = '0;
        issue_a_i     = '0;
        issue_b_i     = '0;
        issue_tag_i   = '0;
        pending       = '0;
        pending_count = 0;
        tag_ptr       = 0;
        rng_state     = SEED;
        build_table();

        repeat (10) @(negedge clock);
        reset = 1'b0;
        check_idle("after reset");

        run_table();
        measure_latency(1'b0, `ALU_SUB, 32'd100, 32'd58, tag_t'(7), 2, "alu latency");
        measure_latency(1'b1, `MUL_LO, 32'd1234, 32'd5678, tag_t'(8), 5, "mult latency");
        run_random();
        run_clear();

        @(negedge clock);
        if (pending_count == 0 && pending == '0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_error("results were left outstanding at the end of the run");
        end
    end

endmodule

/* ex_stage.f */
+incdir+design
design/ex_pkg.sv
design/alu_unit.sv
design/mult_unit.sv
design/complete_buffer.sv
design/ex_stage.sv
sim/ex_stage_tb.sv
